/* Makefile */
TOP := tb_div_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f tb.f --top-module $(TOP)

# The run passes only if the pass line shows up in the simulator output
sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "=== PASS ==="

clean:
	rm -rf obj_dir

/* include/div_macros.svh */
// Divide unit sizing macros

`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// Operand and result width in bits
`define DIV_XLEN 32

// Bit k set places a register after array step k
// Steps 3, 7, 11 ... 31 are registered, which gives eight stages
`define DIV_STAGE_MASK 32'h8888_8888

// Must equal the number of set bits in DIV_STAGE_MASK
`define DIV_STAGES 8

// Result queue depth and the number of credits handed out at reset
`define DIV_CREDITS 4

`endif

/* rtl/div_array.sv */
// Pipelined restoring divide array

`timescale 1ns/1ns
`default_nettype none
`include "div_macros.svh"

module div_array (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        i_valid,
	input  wire div_op_pkg::word_t     i_a,
	input  wire div_op_pkg::word_t     i_b,
	input  wire div_op_pkg::div_op_e   i_op,
	input  wire                        i_neg_q,
	input  wire                        i_neg_r,
	input  wire                        i_div_zero,
	input  wire div_op_pkg::word_t     i_dividend,
	output logic                       o_valid,
	output div_op_pkg::word_t          o_quo,
	output div_op_pkg::word_t          o_rem,
	output div_op_pkg::div_op_e        o_op,
	output logic                       o_neg_q,
	output logic                       o_neg_r,
	output logic                       o_div_zero,
	output div_op_pkg::word_t          o_dividend
);

	localparam int              XLEN = `DIV_XLEN;
	localparam logic [XLEN-1:0] MASK = `DIV_STAGE_MASK;

	// Index k holds the values entering step k, index XLEN is the array output
	logic                v_s    [0:XLEN];
	div_op_pkg::word_t   rem_s  [0:XLEN];
	div_op_pkg::word_t   acc_s  [0:XLEN];
	div_op_pkg::word_t   dvs_s  [0:XLEN];
	div_op_pkg::div_op_e op_s   [0:XLEN];
	logic                nq_s   [0:XLEN];
	logic                nr_s   [0:XLEN];
	logic                dz_s   [0:XLEN];
	div_op_pkg::word_t   dvd_s  [0:XLEN];

	// The accumulator starts as the dividend and fills with quotient bits from the right
	assign v_s[0]   = i_valid;
	assign rem_s[0] = '0;
	assign acc_s[0] = i_a;
	assign dvs_s[0] = i_b;
	assign op_s[0]  = i_op;
	assign nq_s[0]  = i_neg_q;
	assign nr_s[0]  = i_neg_r;
	assign dz_s[0]  = i_div_zero;
	assign dvd_s[0] = i_dividend;

	////////////////////////////////////////
	// Compare and subtract chain
	////////////////////////////////////////

	for (genvar k = 0; k < XLEN; k++) begin : gen_step
		logic              [XLEN:0] trial;
		logic              [XLEN:0] diff;
		logic                       q;
		div_op_pkg::word_t          rem_n;
		div_op_pkg::word_t          acc_n;

		// Bring down the next dividend bit and try the subtraction
		always_comb begin
			trial = {rem_s[k], acc_s[k][XLEN-1]};
			diff  = trial - {1'b0, dvs_s[k]};
			// No borrow out means the divisor fits, so this quotient bit is set
			q     = ~diff[XLEN];
			rem_n = q ? diff[XLEN-1:0] : trial[XLEN-1:0];
			acc_n = {acc_s[k][XLEN-2:0], q};
		end

		if (MASK[k]) begin : gen_reg
			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					v_s[k+1] <= 1'b0;
				end else begin
					v_s[k+1] <= v_s[k];
				end
			end

			// Sideband moves with the data so every stage stays self-contained
			always_ff @(posedge clk) begin
				rem_s[k+1] <= rem_n;
				acc_s[k+1] <= acc_n;
				dvs_s[k+1] <= dvs_s[k];
				op_s[k+1]  <= op_s[k];
				nq_s[k+1]  <= nq_s[k];
				nr_s[k+1]  <= nr_s[k];
				dz_s[k+1]  <= dz_s[k];
				dvd_s[k+1] <= dvd_s[k];
			end
		end else begin : gen_comb
			assign v_s[k+1]   = v_s[k];
			assign rem_s[k+1] = rem_n;
			assign acc_s[k+1] = acc_n;
			assign dvs_s[k+1] = dvs_s[k];
			assign op_s[k+1]  = op_s[k];
			assign nq_s[k+1]  = nq_s[k];
			assign nr_s[k+1]  = nr_s[k];
			assign dz_s[k+1]  = dz_s[k];
			assign dvd_s[k+1] = dvd_s[k];
		end
	end

	// After the last step the accumulator holds only quotient bits
	assign o_valid    = v_s[XLEN];
	assign o_quo      = acc_s[XLEN];
	assign o_rem      = rem_s[XLEN];
	assign o_op       = op_s[XLEN];
	assign o_neg_q    = nq_s[XLEN];
	assign o_neg_r    = nr_s[XLEN];
	assign o_div_zero = dz_s[XLEN];
	assign o_dividend = dvd_s[XLEN];

	// Credit accounting elsewhere assumes this stage count
	a_stage_count: assert property (@(posedge clk) $countones(MASK) == `DIV_STAGES);

endmodule

`default_nettype wire

/* rtl/div_decode.sv */
// Divide decode stage

`timescale 1ns/1ns
`default_nettype none
`include "div_macros.svh"

module div_decode (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        i_valid,
	input  wire div_op_pkg::div_op_e   i_op,
	input  wire div_op_pkg::word_t     i_a,
	input  wire div_op_pkg::word_t     i_b,
	output logic                       o_valid,
	output div_op_pkg::div_op_e        o_op,
	output div_op_pkg::word_t          o_mag_a,
	output div_op_pkg::word_t          o_mag_b,
	output logic                       o_neg_q,
	output logic                       o_neg_r,
	output logic                       o_div_zero,
	output div_op_pkg::word_t          o_dividend
);

	logic              sgn;
	logic              neg_a;
	logic              neg_b;
	div_op_pkg::word_t mag_a;
	div_op_pkg::word_t mag_b;

	// Only the signed opcodes look at the operand sign bits
	always_comb begin
		sgn   = div_op_pkg::is_signed(i_op);
		neg_a = sgn & i_a[`DIV_XLEN-1];
		neg_b = sgn & i_b[`DIV_XLEN-1];
		// The most negative value maps onto itself, which is its correct magnitude unsigned
		mag_a = neg_a ? -i_a : i_a;
		mag_b = neg_b ? -i_b : i_b;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
		end
	end

	// Quotient sign follows the sign difference, remainder sign follows the dividend
	always_ff @(posedge clk) begin
		if (i_valid) begin
			o_op       <= i_op;
			o_mag_a    <= mag_a;
			o_mag_b    <= mag_b;
			o_neg_q    <= neg_a ^ neg_b;
			o_neg_r    <= neg_a;
			o_div_zero <= (i_b == '0);
			// The untouched dividend is the REM result when the divisor is zero
			o_dividend <= i_a;
		end
	end

endmodule

`default_nettype wire

/* rtl/div_flow_pkg.sv */
// Divide flow control types

`default_nettype none
`include "div_macros.svh"

package div_flow_pkg;

	// Fill level of the result queue as seen by the dequeue side
	typedef enum logic [1:0] {
		Q_EMPTY   = 2'd0,
		Q_PARTIAL = 2'd1,
		Q_FULL    = 2'd2
	} queue_state_e;

	// Holds any count from zero up to and including DIV_CREDITS
	typedef logic [$clog2(`DIV_CREDITS+1)-1:0] credit_t;

endpackage

`default_nettype wire

/* rtl/div_op_pkg.sv */
// Divide arithmetic types

`default_nettype none
`include "div_macros.svh"

package div_op_pkg;

	// Low two bits of the RV32M funct3 field for the divide group
	typedef enum logic [1:0] {
		OP_DIV  = 2'b00,
		OP_DIVU = 2'b01,
		OP_REM  = 2'b10,
		OP_REMU = 2'b11
	} div_op_e;

	// One operand or result word
	typedef logic [`DIV_XLEN-1:0] word_t;

	// DIV and REM treat their operands as two's complement
	function automatic logic is_signed(div_op_e op);
		return (op == OP_DIV) || (op == OP_REM);
	endfunction

	// REM and REMU return the remainder instead of the quotient
	function automatic logic is_rem(div_op_e op);
		return (op == OP_REM) || (op == OP_REMU);
	endfunction

endpackage

`default_nettype wire

/* rtl/div_result.sv */
// Divide result stage and queue

`timescale 1ns/1ns
`default_nettype none
`include "div_macros.svh"

module div_result (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        i_valid,
	input  wire div_op_pkg::word_t     i_quo,
	input  wire div_op_pkg::word_t     i_rem,
	input  wire div_op_pkg::div_op_e   i_op,
	input  wire                        i_neg_q,
	input  wire                        i_neg_r,
	input  wire                        i_div_zero,
	input  wire div_op_pkg::word_t     i_dividend,
	input  wire                        i_res_ready,
	output logic                       o_res_valid,
	output div_op_pkg::word_t          o_res_data,
	output logic                       o_credit_return
);

	localparam int DEPTH = `DIV_CREDITS;
	localparam int AW    = $clog2(DEPTH);

	div_op_pkg::word_t          quo_f;
	div_op_pkg::word_t          rem_f;
	div_op_pkg::word_t          sel;
	logic                       fix_valid;
	div_op_pkg::word_t          fix_data;
	div_op_pkg::word_t          mem [0:DEPTH-1];
	logic              [AW-1:0] wr_ptr;
	logic              [AW-1:0] rd_ptr;
	div_flow_pkg::credit_t      count;
	div_flow_pkg::queue_state_e q_state;
	logic                       push;
	logic                       pop;

	////////////////////////////////////////
	// Sign fix-up
	////////////////////////////////////////

	always_comb begin
		quo_f = i_neg_q ? -i_quo : i_quo;
		rem_f = i_neg_r ? -i_rem : i_rem;
		// RISC-V defines x/0 as all ones and x%0 as x, with no trap
		if (i_div_zero) begin
			quo_f = '1;
			rem_f = i_dividend;
		end
		sel = div_op_pkg::is_rem(i_op) ? rem_f : quo_f;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fix_valid <= 1'b0;
		end else begin
			fix_valid <= i_valid;
		end
	end

	always_ff @(posedge clk) begin
		fix_data <= sel;
	end

	////////////////////////////////////////
	// Result queue
	////////////////////////////////////////

	always_comb begin
		if (count == '0) begin
			q_state = div_flow_pkg::Q_EMPTY;
		end else if (count == div_flow_pkg::credit_t'(DEPTH)) begin
			q_state = div_flow_pkg::Q_FULL;
		end else begin
			q_state = div_flow_pkg::Q_PARTIAL;
		end
	end

	// Credits keep the queue from ever filling past DEPTH, so push is never refused
	assign push = fix_valid;
	assign pop  = (q_state != div_flow_pkg::Q_EMPTY) & i_res_ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			count <= count + div_flow_pkg::credit_t'(push) - div_flow_pkg::credit_t'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= fix_data;
		end
	end

	// Head entry stays put until the consumer takes it
	assign o_res_valid     = (q_state != div_flow_pkg::Q_EMPTY);
	assign o_res_data      = mem[rd_ptr];
	// A slot freed here is a credit back to the requester
	assign o_credit_return = pop;

	// A requester that overspends its credits would land a write on a full queue
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		push |-> q_state != div_flow_pkg::Q_FULL);

endmodule

`default_nettype wire

/* rtl/div_unit_top.sv */
// Divide unit top level

`timescale 1ns/1ns
`default_nettype none

module div_unit_top (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        i_req_valid,
	input  wire div_op_pkg::div_op_e   i_req_op,
	input  wire div_op_pkg::word_t     i_req_a,
	input  wire div_op_pkg::word_t     i_req_b,
	input  wire                        i_res_ready,
	output logic                       o_res_valid,
	output div_op_pkg::word_t          o_res_data,
	output logic                       o_credit_return
);

	// Decode to array
	logic                dec_valid;
	div_op_pkg::div_op_e dec_op;
	div_op_pkg::word_t   dec_mag_a;
	div_op_pkg::word_t   dec_mag_b;
	logic                dec_neg_q;
	logic                dec_neg_r;
	logic                dec_div_zero;
	div_op_pkg::word_t   dec_dividend;

	// Array to result
	logic                arr_valid;
	div_op_pkg::word_t   arr_quo;
	div_op_pkg::word_t   arr_rem;
	div_op_pkg::div_op_e arr_op;
	logic                arr_neg_q;
	logic                arr_neg_r;
	logic                arr_div_zero;
	div_op_pkg::word_t   arr_dividend;

	div_decode u_div_decode (
		.clk(clk), .rst(rst),
		.i_valid(i_req_valid), .i_op(i_req_op), .i_a(i_req_a), .i_b(i_req_b),
		.o_valid(dec_valid), .o_op(dec_op), .o_mag_a(dec_mag_a), .o_mag_b(dec_mag_b),
		.o_neg_q(dec_neg_q), .o_neg_r(dec_neg_r), .o_div_zero(dec_div_zero),
		.o_dividend(dec_dividend)
	);

	div_array u_div_array (
		.clk(clk), .rst(rst),
		.i_valid(dec_valid), .i_a(dec_mag_a), .i_b(dec_mag_b), .i_op(dec_op),
		.i_neg_q(dec_neg_q), .i_neg_r(dec_neg_r), .i_div_zero(dec_div_zero),
		.i_dividend(dec_dividend),
		.o_valid(arr_valid), .o_quo(arr_quo), .o_rem(arr_rem), .o_op(arr_op),
		.o_neg_q(arr_neg_q), .o_neg_r(arr_neg_r), .o_div_zero(arr_div_zero),
		.o_dividend(arr_dividend)
	);

	div_result u_div_result (
		.clk(clk), .rst(rst),
		.i_valid(arr_valid), .i_quo(arr_quo), .i_rem(arr_rem), .i_op(arr_op),
		.i_neg_q(arr_neg_q), .i_neg_r(arr_neg_r), .i_div_zero(arr_div_zero),
		.i_dividend(arr_dividend), .i_res_ready(i_res_ready),
		.o_res_valid(o_res_valid), .o_res_data(o_res_data),
		.o_credit_return(o_credit_return)
	);

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
rtl/div_op_pkg.sv
rtl/div_flow_pkg.sv
rtl/div_decode.sv
rtl/div_array.sv
rtl/div_result.sv
rtl/div_unit_top.sv
tests/tb_clock.sv
tests/tb_div_unit.sv

/* tests/tb_clock.sv */
// Testbench clock source

`timescale 1ns/1ns
`default_nettype none

module tb_clock (
	output logic o_clk
);

	// Toggle every 2 ns for a 4 ns period
	initial o_clk = 1'b0;
	always #2 o_clk = ~o_clk;

endmodule

`default_nettype wire

/* tests/tb_div_unit.sv */
// Divide unit testbench

`timescale 1ns/1ns
`default_nettype none
`include "div_macros.svh"

module tb_div_unit;

	localparam int                LIMIT   = 200;
	localparam int                PIPE    = `DIV_STAGES + 2;
	localparam div_op_pkg::word_t MIN_VAL = {1'b1, {(`DIV_XLEN-1){1'b0}}};

	logic                       clk;
	logic                       rst;
	logic                       i_req_valid;
	div_op_pkg::div_op_e        i_req_op;
	div_op_pkg::word_t          i_req_a;
	div_op_pkg::word_t          i_req_b;
	logic                       i_res_ready;
	logic                       o_res_valid;
	div_op_pkg::word_t          o_res_data;
	logic                       o_credit_return;

	// Expected results in issue order sit in a ring indexed by the running counts
	div_op_pkg::word_t          exp_mem [0:255];
	div_op_pkg::word_t          exp_head;
	div_op_pkg::word_t          held_data;
	int                         n_issued;
	int                         n_accepted;
	int                         n_returned;
	int                         n_arrived;
	int                         credits_int;
	div_flow_pkg::credit_t      credits;
	logic [PIPE-1:0]            issue_pipe;
	div_flow_pkg::queue_state_e model_state;

	tb_clock u_tb_clock (.o_clk(clk));

	div_unit_top u_div_unit_top (
		.clk(clk), .rst(rst),
		.i_req_valid(i_req_valid), .i_req_op(i_req_op), .i_req_a(i_req_a), .i_req_b(i_req_b),
		.i_res_ready(i_res_ready),
		.o_res_valid(o_res_valid), .o_res_data(o_res_data), .o_credit_return(o_credit_return)
	);

	assign exp_head    = exp_mem[n_accepted[7:0]];
	// Credits held by the requester, counted from issues and returned pulses
	assign credits_int = `DIV_CREDITS - n_issued + n_returned;
	assign credits     = div_flow_pkg::credit_t'(credits_int);

	task automatic report_mismatch(string name, div_op_pkg::word_t got, div_op_pkg::word_t exp);
		$display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
		$display("=== FAIL ===");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic abort_run(string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		$display("=== FAIL ===");
		$fatal(1, "%s", msg);
	endtask

	////////////////////////////////////////
	// Reference model of the RV32M rules
	////////////////////////////////////////

	function automatic div_op_pkg::word_t expect_result(div_op_pkg::div_op_e op,
		div_op_pkg::word_t a, div_op_pkg::word_t b);
		logic signed [`DIV_XLEN-1:0] sa;
		logic signed [`DIV_XLEN-1:0] sb;
		logic                        ovf;
		sa  = a;
		sb  = b;
		// The one signed quotient that does not fit in XLEN bits
		ovf = (a == MIN_VAL) && (b == '1);
		case (op)
			div_op_pkg::OP_DIVU: return (b == '0) ? '1 : a / b;
			div_op_pkg::OP_REMU: return (b == '0) ? a : a % b;
			div_op_pkg::OP_DIV: begin
				if (b == '0) return '1;
				if (ovf) return a;
				return sa / sb;
			end
			default: begin
				if (b == '0) return a;
				if (ovf) return '0;
				// Sign of the remainder follows the dividend
				return sa % sb;
			end
		endcase
	endfunction

	// Mixes small values of both signs, corner values and full random words
	function automatic div_op_pkg::word_t pick_operand();
		case ($urandom % 6)
			0: return div_op_pkg::word_t'($urandom % 16);
			1: return -(div_op_pkg::word_t'($urandom % 16));
			2: return MIN_VAL;
			3: return '1;
			4: return $urandom >> ($urandom % 32);
			default: return $urandom;
		endcase
	endfunction

	// Result arrival times follow from the fixed pipeline latency
	always @(posedge clk or posedge rst) begin
		if (rst) begin
			issue_pipe <= '0;
			n_arrived  <= 0;
			n_accepted <= 0;
			n_returned <= 0;
			held_data  <= '0;
		end else begin
			issue_pipe <= {issue_pipe[PIPE-2:0], i_req_valid};
			n_arrived  <= n_arrived + int'(issue_pipe[PIPE-1]);
			if (o_res_valid && i_res_ready) n_accepted <= n_accepted + 1;
			if (o_credit_return) n_returned <= n_returned + 1;
			held_data  <= o_res_data;
		end
	end

	always_comb begin
		if (n_arrived == n_accepted) begin
			model_state = div_flow_pkg::Q_EMPTY;
		end else if (n_arrived - n_accepted == `DIV_CREDITS) begin
			model_state = div_flow_pkg::Q_FULL;
		end else begin
			model_state = div_flow_pkg::Q_PARTIAL;
		end
	end

	////////////////////////////////////////
	// Checking assertions
	////////////////////////////////////////

	a_reset_quiet: assert property (@(posedge clk)
		n_issued == 0 |-> !o_res_valid && !o_credit_return)
		else abort_run("result or credit pulse seen before the first issue");

	a_res_data: assert property (@(posedge clk) disable iff (rst)
		o_res_valid && i_res_ready |-> o_res_data == exp_head)
		else report_mismatch("o_res_data", $sampled(o_res_data), $sampled(exp_head));

	// Valid must rise exactly DIV_STAGES+2 cycles after each issue while results queue
	a_res_timing: assert property (@(posedge clk) disable iff (rst)
		o_res_valid == (model_state != div_flow_pkg::Q_EMPTY))
		else report_mismatch("o_res_valid", 32'($sampled(o_res_valid)),
			32'($sampled(model_state != div_flow_pkg::Q_EMPTY)));

	a_queue_bound: assert property (@(posedge clk) disable iff (rst)
		n_arrived - n_accepted <= `DIV_CREDITS)
		else abort_run("more results waiting than the queue can hold");

	a_valid_hold: assert property (@(posedge clk) disable iff (rst)
		o_res_valid && !i_res_ready |=> o_res_valid)
		else abort_run("o_res_valid dropped before the result was accepted");

	a_data_hold: assert property (@(posedge clk) disable iff (rst)
		o_res_valid && !i_res_ready |=> o_res_data == held_data)
		else report_mismatch("o_res_data", $sampled(o_res_data), $sampled(held_data));

	a_credit_sum: assert property (@(posedge clk) disable iff (rst)
		credits_int + (n_issued - n_accepted) == `DIV_CREDITS)
		else report_mismatch("credit sum", 32'($sampled(credits_int + n_issued - n_accepted)),
			32'(`DIV_CREDITS));

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	// Called 1 ns after a rising edge, returns at the same point of a later cycle
	task automatic wait_for_credit();
		int n;
		n = 0;
		while (credits == '0 && n < LIMIT) begin
			i_res_ready = 1'b1;
			@(posedge clk);
			#1;
			n++;
		end
		if (credits == '0) abort_run("timed out waiting for a credit");
	endtask

	task automatic issue(div_op_pkg::div_op_e op, div_op_pkg::word_t a, div_op_pkg::word_t b);
		wait_for_credit();
		i_req_valid = 1'b1;
		i_req_op    = op;
		i_req_a     = a;
		i_req_b     = b;
		exp_mem[n_issued[7:0]] = expect_result(op, a, b);
		n_issued++;
		@(posedge clk);
		#1;
		i_req_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (n_accepted != n_issued && n < LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (n_accepted != n_issued) abort_run("timed out waiting for results to drain");
	endtask

	task automatic wait_queued();
		int n;
		n = 0;
		while (n_arrived != n_issued && n < LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (n_arrived != n_issued) abort_run("timed out waiting for results to reach the queue");
	endtask

	initial begin
		int ret_base;
		void'($urandom(49));
		rst         = 1'b1;
		i_req_valid = 1'b0;
		i_req_op    = div_op_pkg::OP_DIV;
		i_req_a     = '0;
		i_req_b     = '0;
		i_res_ready = 1'b0;
		n_issued    = 0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;

		// Outputs must stay quiet while idle with the consumer ready
		i_res_ready = 1'b1;
		repeat (6) begin
			@(posedge clk);
			#1;
		end

		// The timing assertion pins the latency of back-to-back issues
		for (int i = 0; i < 8; i++) begin
			issue(div_op_pkg::OP_DIVU, $urandom, div_op_pkg::word_t'(i + 1));
		end
		wait_drain();

		// Random opcodes and operands under random back-pressure
		for (int i = 0; i < 300; i++) begin
			i_res_ready = ($urandom % 4) != 0;
			issue(div_op_pkg::div_op_e'($urandom % 4), pick_operand(), pick_operand());
		end
		i_res_ready = 1'b1;
		wait_drain();

		// Divide by zero and signed overflow for every opcode
		for (int op = 0; op < 4; op++) begin
			issue(div_op_pkg::div_op_e'(op), $urandom, '0);
			issue(div_op_pkg::div_op_e'(op), MIN_VAL, '0);
			issue(div_op_pkg::div_op_e'(op), '0, '0);
			issue(div_op_pkg::div_op_e'(op), MIN_VAL, '1);
		end
		wait_drain();

		// Spend every credit while the consumer stalls
		i_res_ready = 1'b0;
		ret_base    = n_returned;
		while (credits != '0) begin
			issue(div_op_pkg::div_op_e'($urandom % 4), $urandom, $urandom | 1);
		end
		wait_queued();
		repeat (5) begin
			@(posedge clk);
			#1;
		end
		i_res_ready = 1'b1;
		wait_drain();
		assert (n_returned - ret_base == `DIV_CREDITS)
			else report_mismatch("o_credit_return count", n_returned - ret_base, `DIV_CREDITS);

		repeat (3) begin
			@(posedge clk);
			#1;
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire
